// ==== Bender.yml ====
package:
  name: ql_bus_glue

sources:
  - rtl/ql_bus_pkg.sv
  - rtl/ql_clock_enables.sv
  - rtl/ql_mem_decode.sv
  - rtl/ql_io_regs.sv
  - rtl/ql_data_steer.sv
  - rtl/ql_bus_glue.sv
  - target: simulation
    files:
      - sim/ql_bus_checker.sv
      - sim/tb_ql_bus_glue.sv

// ==== list.f ====
rtl/ql_bus_pkg.sv
rtl/ql_clock_enables.sv
rtl/ql_mem_decode.sv
rtl/ql_io_regs.sv
rtl/ql_data_steer.sv
rtl/ql_bus_glue.sv
sim/ql_bus_checker.sv
sim/tb_ql_bus_glue.sv

// ==== rtl/ql_bus_glue.sv ====
// RAM size is taken only while reset is high; bus request must hold until cpu_dtack
`timescale 1ns/1ps

module ql_bus_glue
(
	input  logic                    clk_sys,
	input  logic                    reset,
	input  ql_bus_pkg::bus_speed_t  speed,
	input  ql_bus_pkg::ram_cfg_t    ram_cfg,
	input  ql_bus_pkg::bus_req_t    bus,
	input  ql_bus_pkg::src_data_t   src,
	input  logic                    sdram_dtack,
	input  logic                    qlsd_dtack,
	input  logic                    ram_delay_dtack,
	output logic [15:0]             cpu_din,
	output logic                    cpu_dtack,
	output ql_bus_pkg::sdram_req_t  sdram,
	output ql_bus_pkg::periph_sel_t sel,
	output logic [7:0]              mc_stat,
	output logic                    rom_shadow,
	output logic                    ce_bus_p,
	output logic                    ce_bus_n,
	output logic                    ce_131k
);

	ql_bus_pkg::ram_cfg_t          ram_cfg_q;
	ql_bus_pkg::mem_region_t       region;
	logic                          gc_en;
	logic [ql_bus_pkg::ADDR_W-1:0] addr_mask;
	logic [ql_bus_pkg::ADDR_W-1:0] cpu_addr;

	// Config follows the input during reset, frozen after
	always_ff @(posedge clk_sys)
	begin
		if (reset)
			ram_cfg_q <= ram_cfg;
	end

	assign gc_en = (ram_cfg_q == ql_bus_pkg::RAM_4096K);

	always_comb
	begin
		case (ram_cfg_q)
			ql_bus_pkg::RAM_128K: addr_mask = ql_bus_pkg::WRAP_128K;
			ql_bus_pkg::RAM_640K,
			ql_bus_pkg::RAM_896K: addr_mask = ql_bus_pkg::WRAP_1M;
			default:              addr_mask = ql_bus_pkg::WRAP_8M;
		endcase
	end

	// A0 rebuilt from the strobes, 68008 style
	assign cpu_addr = {bus.addr[ql_bus_pkg::ADDR_W-1:1], !bus.uds && bus.lds} & addr_mask;

	// ==========================================================
	// Blocks
	// ==========================================================
	ql_clock_enables u_clock_enables (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.speed    (speed),
		.ce_bus_p (ce_bus_p),
		.ce_bus_n (ce_bus_n),
		.ce_131k  (ce_131k)
	);

	ql_mem_decode u_mem_decode (
		.addr    (cpu_addr),
		.ram_cfg (ram_cfg_q),
		.region  (region)
	);

	ql_io_regs u_io_regs (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.bus        (bus),
		.addr       (cpu_addr),
		.gc_en      (gc_en),
		.sel        (sel),
		.mc_stat    (mc_stat),
		.rom_shadow (rom_shadow)
	);

	ql_data_steer u_data_steer (
		.bus             (bus),
		.region          (region),
		.sel             (sel),
		.rom_shadow      (rom_shadow),
		.gc_en           (gc_en),
		.addr            (cpu_addr),
		.src             (src),
		.sdram_dtack     (sdram_dtack),
		.qlsd_dtack      (qlsd_dtack),
		.ram_delay_dtack (ram_delay_dtack),
		.cpu_din         (cpu_din),
		.cpu_dtack       (cpu_dtack),
		.sdram           (sdram)
	);

	// Decode and shadow state together must never ask SDRAM to read and write at once
	a_sdram_strobes: assert property (@(posedge clk_sys) disable iff (reset)
		!(sdram.wr && sdram.oe));

endmodule

// ==== rtl/ql_bus_pkg.sv ====
// Shared bus types and memory map; increments and divider assume an 84 MHz clk_sys
package ql_bus_pkg;

	// ==========================================================
	// Constants
	// ==========================================================
	localparam int ADDR_W = 24;                          // 68008 address bus

	// Phase increments for 84 MHz, 65536 ticks every clock
	localparam logic [16:0] FRACT_BUS_QL   = 17'd11702;  // ~15 MHz
	localparam logic [16:0] FRACT_BUS_16   = 17'd24966;  // ~32 MHz
	localparam logic [16:0] FRACT_BUS_24   = 17'd37449;  // ~48 MHz
	localparam logic [16:0] FRACT_BUS_FULL = 17'd65536;  // Every clock

	localparam logic [9:0] DIV_131K = 10'd640;           // 84 MHz / 640 = 131.25 kHz

	// Address wrap masks per RAM size
	localparam logic [ADDR_W-1:0] WRAP_128K = 24'h03FFFF; // 256k space
	localparam logic [ADDR_W-1:0] WRAP_1M   = 24'h0FFFFF; // 640k and 896k
	localparam logic [ADDR_W-1:0] WRAP_8M   = 24'h7FFFFF; // 4M RAM plus ext I/O

	// GoldCard I/O page offsets
	localparam logic [7:0] GC_SHADOW_ON_OFFS  = 8'h60;   // glo_rena
	localparam logic [7:0] GC_SHADOW_OFF_OFFS = 8'h64;   // glo_rdis

	// ==========================================================
	// Enums
	// ==========================================================
	typedef enum logic [1:0] {
		SPEED_QL   = 2'b00,
		SPEED_16   = 2'b01,
		SPEED_24   = 2'b10,
		SPEED_FULL = 2'b11
	} bus_speed_t;

	typedef enum logic [1:0] {
		RAM_128K  = 2'b00,
		RAM_640K  = 2'b01,
		RAM_896K  = 2'b10,
		RAM_4096K = 2'b11      // Also GoldCard mode
	} ram_cfg_t;

	// ==========================================================
	// Structs
	// ==========================================================
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic              as;
		logic              rw;   // 1 = read
		logic              uds;
		logic              lds;
		logic [15:0]       dout; // CPU write data
	} bus_req_t;

	typedef struct packed {
		logic rom;          // $00000-$0ffff
		logic os_rom;       // $00000-$0bfff
		logic ext_rom;      // $0c000-$0ffff
		logic ram;          // Any RAM
		logic gc_boot_rom;  // $04xxxx copy
		logic gc_os_rom;    // $40xxxx copy
		logic qlsd_rd;      // Data register $fee4
		logic qlsd_sel;     // Any QL-SD window
	} mem_region_t;

	typedef struct packed {
		logic ql_io;
		logic zx8302_sel;
		logic qimi_sel;
	} periph_sel_t;

	typedef struct packed {
		logic [15:0] sdram_dout;
		logic [15:0] ql_rom_dout;
		logic [15:0] gc_rom_dout;
		logic [15:0] zx8302_dout;
		logic [7:0]  qimi_data;
		logic [7:0]  qlsd_dout;
	} src_data_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr; // Word address
		logic              wr;
		logic              oe;
	} sdram_req_t;

endpackage

// ==== rtl/ql_clock_enables.sv ====
// Enables are single-cycle pulses; bus rates are exact only at an 84 MHz clk_sys
`timescale 1ns/1ps

module ql_clock_enables
(
	input  logic                   clk_sys,
	input  logic                   reset,
	input  ql_bus_pkg::bus_speed_t speed,
	output logic                   ce_bus_p,
	output logic                   ce_bus_n,
	output logic                   ce_131k
);

	logic [16:0] fract_bus;
	logic [16:0] cnt_sum;
	logic [15:0] cnt_bus;   // Phase accumulator
	logic        bus_pol;   // 0 = next tick is p
	logic [9:0]  div_131k;

	always_comb
	begin
		case (speed)
			ql_bus_pkg::SPEED_QL: fract_bus = ql_bus_pkg::FRACT_BUS_QL;
			ql_bus_pkg::SPEED_16: fract_bus = ql_bus_pkg::FRACT_BUS_16;
			ql_bus_pkg::SPEED_24: fract_bus = ql_bus_pkg::FRACT_BUS_24;
			default:              fract_bus = ql_bus_pkg::FRACT_BUS_FULL;
		endcase
	end

	assign cnt_sum = {1'b0, cnt_bus} + fract_bus; // Carry out is the tick

	// ==========================================================
	// CPU bus phases
	// ==========================================================
	always_ff @(posedge clk_sys)
	begin
		if (reset)
		begin
			cnt_bus  <= '0;
			bus_pol  <= 1'b0;
			ce_bus_p <= 1'b0;
			ce_bus_n <= 1'b0;
		end
		else
		begin
			cnt_bus  <= cnt_sum[15:0];
			ce_bus_p <= cnt_sum[16] && !bus_pol;
			ce_bus_n <= cnt_sum[16] && bus_pol;
			bus_pol  <= bus_pol ^ cnt_sum[16]; // Flip on every tick
		end
	end

	// Refresh and RTC update, fires on count zero
	always_ff @(posedge clk_sys)
	begin
		if (reset)
		begin
			div_131k <= '0;
			ce_131k  <= 1'b0;
		end
		else
		begin
			div_131k <= (div_131k == ql_bus_pkg::DIV_131K - 10'd1) ? 10'd0 : div_131k + 10'd1;
			ce_131k  <= (div_131k == 10'd0);
		end
	end

	a_bus_phase_excl: assert property (@(posedge clk_sys) disable iff (reset)
		!(ce_bus_p && ce_bus_n));

	// A p phase is always followed by an n phase before the next p
	a_bus_alternate: assert property (@(posedge clk_sys) disable iff (reset)
		ce_bus_p |=> (!ce_bus_p until ce_bus_n));

endmodule

// ==== rtl/ql_data_steer.sv ====
// Purely combinational; inputs must hold for the whole AS cycle until DTACK
`timescale 1ns/1ps

module ql_data_steer
(
	input  ql_bus_pkg::bus_req_t          bus,
	input  ql_bus_pkg::mem_region_t       region,
	input  ql_bus_pkg::periph_sel_t       sel,
	input  logic                          rom_shadow,
	input  logic                          gc_en,
	input  logic [ql_bus_pkg::ADDR_W-1:0] addr,
	input  ql_bus_pkg::src_data_t         src,
	input  logic                          sdram_dtack,
	input  logic                          qlsd_dtack,
	input  logic                          ram_delay_dtack,
	output logic [15:0]                   cpu_din,
	output logic                          cpu_dtack,
	output ql_bus_pkg::sdram_req_t        sdram
);

	logic        cpu_rd;
	logic        qlsd_en;
	logic        qlsd_rd;
	logic        qlsd_sel;
	logic        shadow_rd;
	logic        shadow_wr;
	logic [15:0] qlsd_word;
	logic [15:0] io_dout;
	logic [15:0] gc_dout_boot;
	logic [15:0] gc_dout_shadow;
	logic [15:0] ql_dout;

	assign cpu_rd = bus.as && bus.rw && (bus.uds || bus.lds);

	// QL-SD is hidden behind the GoldCard ROM until shadow is on
	assign qlsd_en  = (!gc_en || rom_shadow) && cpu_rd;
	assign qlsd_rd  = qlsd_en && region.qlsd_rd;
	assign qlsd_sel = qlsd_en && region.qlsd_sel;

	assign shadow_rd = cpu_rd && region.os_rom && rom_shadow;
	assign shadow_wr = bus.as && !bus.rw && region.os_rom && !rom_shadow; // Copies OS ROM

	// ==========================================================
	// Read data
	// ==========================================================
	assign qlsd_word = {src.qlsd_dout, src.qlsd_dout};   // 8-bit device on both lanes

	assign io_dout = sel.qimi_sel   ? {src.qimi_data, src.qimi_data} :
	                 sel.zx8302_sel ? src.zx8302_dout :
	                                  16'h0000;

	// GoldCard boot, shadow off
	assign gc_dout_boot = region.rom         ? src.gc_rom_dout :
	                      region.gc_boot_rom ? src.gc_rom_dout :
	                      region.gc_os_rom   ? src.ql_rom_dout :
	                      region.ram         ? src.sdram_dout  :
	                                           16'hFFFF;

	// Shadow on, OS runs from SDRAM
	assign gc_dout_shadow = region.os_rom    ? src.sdram_dout  :
	                        qlsd_rd          ? qlsd_word       :
	                        region.ext_rom   ? src.ql_rom_dout :
	                        region.gc_os_rom ? src.ql_rom_dout :
	                        region.ram       ? src.sdram_dout  :
	                                           16'hFFFF;

	assign ql_dout = qlsd_rd    ? qlsd_word       :
	                 region.rom ? src.ql_rom_dout :
	                 region.ram ? src.sdram_dout  :
	                              16'hFFFF;       // Unmapped

	assign cpu_din = sel.ql_io ? io_dout :
	                 gc_en     ? (rom_shadow ? gc_dout_shadow : gc_dout_boot) :
	                             ql_dout;

	// ==========================================================
	// Handshake and SDRAM strobes
	// ==========================================================
	assign cpu_dtack = qlsd_sel                ? qlsd_dtack :
	                   shadow_rd || shadow_wr  ? sdram_dtack :
	                   region.ram              ? sdram_dtack && !ram_delay_dtack :
	                                             !ram_delay_dtack;

	assign sdram.addr = {3'b000, addr[21:1]};      // 16-bit words
	assign sdram.wr   = bus.as && !bus.rw && (region.ram || shadow_wr);
	assign sdram.oe   = cpu_rd && (region.ram || shadow_rd);

endmodule

// ==== rtl/ql_io_regs.sv ====
// Both registers are write-only; shadow control only responds in GoldCard mode
`timescale 1ns/1ps

module ql_io_regs
(
	input  logic                          clk_sys,
	input  logic                          reset,
	input  ql_bus_pkg::bus_req_t          bus,
	input  logic [ql_bus_pkg::ADDR_W-1:0] addr,
	input  logic                          gc_en,
	output ql_bus_pkg::periph_sel_t       sel,
	output logic [7:0]                    mc_stat,
	output logic                          rom_shadow
);

	logic cpu_rd;
	logic cpu_wr;
	logic cpu_io;
	logic ql_io;
	logic qimi_hit;
	logic gc_io;
	logic zx8301_ce;
	logic shadow_wr;

	assign cpu_rd = bus.as && bus.rw && (bus.uds || bus.lds);
	assign cpu_wr = bus.as && !bus.rw && (bus.uds || bus.lds);
	assign cpu_io = cpu_rd || cpu_wr;

	// ==========================================================
	// I/O space decode
	// ==========================================================
	assign ql_io    = (addr[23:14] == 10'h006);    // $18000-$1bfff
	assign qimi_hit = (addr[13:8] == 6'h3F);       // Mouse at $1bfxx
	assign gc_io    = gc_en && (addr[23:8] == 16'h01C0); // $1c0xx page

	assign sel.ql_io      = ql_io;
	assign sel.qimi_sel   = cpu_io && ql_io && qimi_hit;
	assign sel.zx8302_sel = cpu_io && ql_io && !addr[6] && !qimi_hit; // Mouse page wins

	// Display control at $18063 on the low byte only
	assign zx8301_ce = ql_io && ({addr[6:5], addr[1]} == 3'b111) && cpu_wr && bus.lds;

	// GoldCard registers are hit with upper-byte-only writes
	assign shadow_wr = gc_io && cpu_wr && bus.uds && !bus.lds;

	always_ff @(posedge clk_sys)
	begin
		if (reset)
			mc_stat <= 8'h00;
		else if (zx8301_ce)
			mc_stat <= bus.dout[7:0];
	end

	always_ff @(posedge clk_sys)
	begin
		if (reset)
			rom_shadow <= 1'b0;
		else if (shadow_wr)
		begin
			if (addr[7:0] == ql_bus_pkg::GC_SHADOW_ON_OFFS)
				rom_shadow <= 1'b1;     // Shadow RAM over OS ROM
			else if (addr[7:0] == ql_bus_pkg::GC_SHADOW_OFF_OFFS)
				rom_shadow <= 1'b0;
		end
	end

	a_sel_excl: assert property (@(posedge clk_sys) disable iff (reset)
		!(sel.zx8302_sel && sel.qimi_sel));

endmodule

// ==== rtl/ql_mem_decode.sv ====
// Address must already be wrapped to the RAM size; QL-SD flags are raw, not yet qualified
`timescale 1ns/1ps

module ql_mem_decode
(
	input  logic [ql_bus_pkg::ADDR_W-1:0] addr,
	input  ql_bus_pkg::ram_cfg_t          ram_cfg,
	output ql_bus_pkg::mem_region_t       region
);

	logic gc_en;
	logic rom;
	logic ext_rom;
	logic bram;
	logic ram512;
	logic ram768;
	logic ram4k;
	logic gc_ram1;
	logic gc_ram2;
	logic qlsd_reg;
	logic qlsd_dat;

	assign gc_en = (ram_cfg == ql_bus_pkg::RAM_4096K); // 4M implies GoldCard

	// ==========================================================
	// ROM and RAM
	// ==========================================================
	assign rom     = (addr[23:16] == 8'h00);       // 64k ROM
	assign ext_rom = (addr[23:14] == 10'h003);     // 16k at $c000
	assign bram    = (addr[23:17] == 7'h01);       // $20000-$3ffff

	// Extended RAM from $40000
	assign ram512 = (ram_cfg == ql_bus_pkg::RAM_640K) && (addr[23:20] == 4'h0)
		&& ^addr[19:18];                             // $40000-$bffff
	assign ram768 = (ram_cfg == ql_bus_pkg::RAM_896K) && (addr[23:20] == 4'h0)
		&& |addr[19:18];                             // $40000-$fffff
	assign ram4k  = gc_en && (addr[23:22] == 2'b00) && |addr[21:18]; // Up to $3fffff

	// SuperGoldCard extra RAM
	assign gc_ram1 = gc_en && (addr[23:15] == 9'h002);  // $10000-$17fff
	// $1c100-$1ffff, page $1c0xx is GoldCard I/O
	assign gc_ram2 = gc_en && (addr[23:14] == 10'h007) && (addr[13:8] != 6'h00);

	// QL-SD windows inside the ext ROM
	assign qlsd_reg = (addr[15:4] == 12'hFEE) || (addr[15:4] == 12'hFEF);
	assign qlsd_dat = (addr[15:8] == 8'hFF);

	// ==========================================================
	// Region flags
	// ==========================================================
	assign region.rom         = rom;
	assign region.ext_rom     = ext_rom;
	assign region.os_rom      = rom && !ext_rom;   // 48k OS
	assign region.ram         = bram || ram512 || ram768 || ram4k || gc_ram1 || gc_ram2;
	assign region.gc_boot_rom = gc_en && (addr[23:16] == 8'h04);
	assign region.gc_os_rom   = gc_en && (addr[23:16] == 8'h40);
	assign region.qlsd_rd     = rom && (addr[15:0] == 16'hFEE4); // Only readable register
	assign region.qlsd_sel    = rom && (qlsd_reg || qlsd_dat);

endmodule

// ==== sim/ql_bus_checker.sv ====
// Compares DUT outputs once per new row number on the rising edge; counts are kept until summary
`timescale 1ns/1ps

module ql_bus_checker
(
	input  logic                    clk_sys,
	input  int                      row_seq,     // Changes once per table row
	input  logic [15:0]             exp_din,
	input  logic                    chk_din,     // Data only checked on reads
	input  logic                    exp_dtack,
	input  logic [1:0]              exp_strb,    // {wr, oe}
	input  logic [23:0]             exp_waddr,   // Only meaningful with a strobe
	input  logic [7:0]              exp_mc,
	input  logic                    exp_shadow,
	input  logic [2:0]              exp_sel,     // {ql_io, zx8302, qimi}
	input  logic [15:0]             cpu_din,
	input  logic                    cpu_dtack,
	input  ql_bus_pkg::sdram_req_t  sdram,
	input  ql_bus_pkg::periph_sel_t sel,
	input  logic [7:0]              mc_stat,
	input  logic                    rom_shadow
);

	int tests = 0;
	int errors = 0;
	int last_seq = 0;

	task automatic compare_field(input string name, input logic [23:0] exp,
		input logic [23:0] got, input string where, inout int errs);
		if (got !== exp)
		begin
			$display("ERROR %s exp %h got %h (%s)", name, exp, got, where);
			errs++;
		end
	endtask

	// ==========================================================
	// Table rows
	// ==========================================================
	always @(posedge clk_sys)
	begin
		int    row_errs;
		string where;
		if (row_seq != last_seq)
		begin
			last_seq = row_seq;
			row_errs = 0;
			where    = $sformatf("row %0d", row_seq);
			if (chk_din)
				compare_field("cpu_din", 24'(exp_din), 24'(cpu_din), where, row_errs);
			compare_field("cpu_dtack", 24'(exp_dtack), 24'(cpu_dtack), where, row_errs);
			compare_field("sdram_wr", 24'(exp_strb[1]), 24'(sdram.wr), where, row_errs);
			compare_field("sdram_oe", 24'(exp_strb[0]), 24'(sdram.oe), where, row_errs);
			if (exp_strb != 2'b00)
				compare_field("sdram_addr", exp_waddr, sdram.addr, where, row_errs);
			compare_field("sel", 24'(exp_sel), 24'(sel), where, row_errs);
			compare_field("mc_stat", 24'(exp_mc), 24'(mc_stat), where, row_errs);
			compare_field("rom_shadow", 24'(exp_shadow), 24'(rom_shadow), where, row_errs);
			tests++;
			errors += row_errs;
			if (row_errs == 0)
				$display("%s: ok", where);
			else
				$display("%s: %0d mismatches", where, row_errs);
		end
	end

	// ==========================================================
	// Called from the testbench
	// ==========================================================
	task automatic check_enables(input string label, input int exp_p, input int got_p,
		input int exp_n, input int got_n, input int exp_131, input int got_131);
		int errs;
		errs = 0;
		compare_field("ce_bus_p count", 24'(exp_p), 24'(got_p), label, errs);
		compare_field("ce_bus_n count", 24'(exp_n), 24'(got_n), label, errs);
		compare_field("ce_131k count", 24'(exp_131), 24'(got_131), label, errs);
		tests++;
		errors += errs;
		if (errs == 0)
			$display("%s: ok", label);
		else
			$display("%s: %0d mismatches", label, errs);
	endtask

	task automatic note_failure(input string msg);
		$display("%s", msg);
		errors++;
	endtask

	task automatic summary(output bit ok);
		$display("%0d tests, %0d errors", tests, errors);
		ok = (errors == 0);
	endtask

endmodule

// ==== sim/tb_ql_bus_glue.sv ====
// Source data are fixed constants; rows run in order and later rows rely on earlier register writes
`timescale 1ns/1ps

module tb_ql_bus_glue;

	localparam int RESET_CYCLES  = 4;
	localparam int DTACK_LIMIT   = 16;     // Clocks to wait for cpu_dtack
	localparam int ENABLE_CLOCKS = 4096;

	typedef struct packed {
		logic        rst;     // Reset with cfg before the request
		logic [1:0]  cfg;     // 0 = 128k, 3 = 4096k GoldCard
		logic [23:0] addr;
		logic        rw;
		logic [1:0]  ds;      // {uds, lds}
		logic [15:0] dout;
		logic [2:0]  acks;    // {sdram, qlsd, ram_delay}
		logic [15:0] din;
		logic        dtack;
		logic [1:0]  strb;    // {wr, oe}
		logic [7:0]  mc;
		logic        shadow;
		logic [2:0]  psel;    // {ql_io, zx8302, qimi}
	} row_t;

	logic                    clk_sys = 1'b0;
	logic                    reset;
	ql_bus_pkg::bus_speed_t  speed;
	ql_bus_pkg::ram_cfg_t    ram_cfg;
	ql_bus_pkg::bus_req_t    bus;
	ql_bus_pkg::src_data_t   src;
	logic                    sdram_dtack;
	logic                    qlsd_dtack;
	logic                    ram_delay_dtack;
	logic [15:0]             cpu_din;
	logic                    cpu_dtack;
	ql_bus_pkg::sdram_req_t  sdram;
	ql_bus_pkg::periph_sel_t sel;
	logic [7:0]              mc_stat;
	logic                    rom_shadow;
	logic                    ce_bus_p;
	logic                    ce_bus_n;
	logic                    ce_131k;

	int          row_seq;
	logic [15:0] exp_din;
	logic        chk_din;
	logic        exp_dtack;
	logic [1:0]  exp_strb;
	logic [23:0] exp_waddr;
	logic [7:0]  exp_mc;
	logic        exp_shadow;
	logic [2:0]  exp_sel;
	row_t        rows[$];
	bit          ok;

	always #20 clk_sys = ~clk_sys;   // 40 ns

	ql_bus_glue dut (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.speed           (speed),
		.ram_cfg         (ram_cfg),
		.bus             (bus),
		.src             (src),
		.sdram_dtack     (sdram_dtack),
		.qlsd_dtack      (qlsd_dtack),
		.ram_delay_dtack (ram_delay_dtack),
		.cpu_din         (cpu_din),
		.cpu_dtack       (cpu_dtack),
		.sdram           (sdram),
		.sel             (sel),
		.mc_stat         (mc_stat),
		.rom_shadow      (rom_shadow),
		.ce_bus_p        (ce_bus_p),
		.ce_bus_n        (ce_bus_n),
		.ce_131k         (ce_131k)
	);

	ql_bus_checker u_checker (
		.clk_sys    (clk_sys),
		.row_seq    (row_seq),
		.exp_din    (exp_din),
		.chk_din    (chk_din),
		.exp_dtack  (exp_dtack),
		.exp_strb   (exp_strb),
		.exp_waddr  (exp_waddr),
		.exp_mc     (exp_mc),
		.exp_shadow (exp_shadow),
		.exp_sel    (exp_sel),
		.cpu_din    (cpu_din),
		.cpu_dtack  (cpu_dtack),
		.sdram      (sdram),
		.sel        (sel),
		.mc_stat    (mc_stat),
		.rom_shadow (rom_shadow)
	);

	task automatic add_row(input logic rst, input logic [1:0] cfg, input logic [23:0] addr,
		input logic rw, input logic [1:0] ds, input logic [15:0] dout, input logic [2:0] acks,
		input logic [15:0] din, input logic dtack, input logic [1:0] strb, input logic [7:0] mc,
		input logic shadow, input logic [2:0] psel);
		row_t r;
		r = {rst, cfg, addr, rw, ds, dout, acks, din, dtack, strb, mc, shadow, psel};
		rows.push_back(r);
	endtask

	// ==========================================================
	// Stimulus table
	// ==========================================================
	// Source words are sdram a001, ql rom b002, gc rom c003, zx8302 d004, qimi 5e, qlsd 7c
	task automatic build_table();
		// rst cfg addr rw {uds,lds} dout {sdram,qlsd,delay} din dtack {wr,oe} mc_stat
		// then shadow and the selects {ql_io,zx8302,qimi}
		add_row(1, 0, 24'h00FEE4, 1, 2'b11, 16'h0000, 3'b010, 16'h7C7C, 1, 2'b00, 8'h00, 0, 0);
		add_row(0, 0, 24'h001000, 1, 2'b11, 16'h0000, 3'b000, 16'hB002, 1, 2'b00, 8'h00, 0, 0);
		add_row(0, 0, 24'h020000, 1, 2'b11, 16'h0000, 3'b100, 16'hA001, 1, 2'b01, 8'h00, 0, 0);
		add_row(0, 0, 24'h020000, 1, 2'b11, 16'h0000, 3'b000, 16'hA001, 0, 2'b01, 8'h00, 0, 0);
		add_row(0, 0, 24'h020000, 1, 2'b11, 16'h0000, 3'b101, 16'hA001, 0, 2'b01, 8'h00, 0, 0);
		add_row(0, 0, 24'h018020, 1, 2'b11, 16'h0000, 3'b000, 16'hD004, 1, 2'b00, 8'h00, 0, 6);
		add_row(0, 0, 24'h01BF00, 1, 2'b11, 16'h0000, 3'b000, 16'h5E5E, 1, 2'b00, 8'h00, 0, 5);
		add_row(0, 0, 24'h010000, 1, 2'b11, 16'h0000, 3'b000, 16'hFFFF, 1, 2'b00, 8'h00, 0, 0);
		add_row(0, 0, 24'h010000, 1, 2'b11, 16'h0000, 3'b001, 16'hFFFF, 0, 2'b00, 8'h00, 0, 0);
		add_row(0, 0, 24'h043000, 1, 2'b11, 16'h0000, 3'b000, 16'hB002, 1, 2'b00, 8'h00, 0, 0);
		add_row(0, 0, 24'h00FF00, 1, 2'b11, 16'h0000, 3'b000, 16'hB002, 0, 2'b00, 8'h00, 0, 0);
		add_row(0, 0, 24'h00FF00, 1, 2'b11, 16'h0000, 3'b011, 16'hB002, 1, 2'b00, 8'h00, 0, 0);
		add_row(0, 0, 24'h018063, 0, 2'b01, 16'h00A5, 3'b000, 16'h0000, 1, 2'b00, 8'h00, 0, 4);
		add_row(0, 0, 24'h002000, 1, 2'b11, 16'h0000, 3'b000, 16'hB002, 1, 2'b00, 8'hA5, 0, 0);
		add_row(1, 0, 24'h002000, 1, 2'b11, 16'h0000, 3'b000, 16'hB002, 1, 2'b00, 8'h00, 0, 0);
		// GoldCard mode with shadow off
		add_row(1, 3, 24'h001000, 1, 2'b11, 16'h0000, 3'b000, 16'hC003, 1, 2'b00, 8'h00, 0, 0);
		add_row(0, 3, 24'h041000, 1, 2'b11, 16'h0000, 3'b100, 16'hC003, 1, 2'b01, 8'h00, 0, 0);
		add_row(0, 3, 24'h401000, 1, 2'b11, 16'h0000, 3'b000, 16'hB002, 1, 2'b00, 8'h00, 0, 0);
		add_row(0, 3, 24'h00FEE4, 1, 2'b11, 16'h0000, 3'b000, 16'hC003, 1, 2'b00, 8'h00, 0, 0);
		add_row(0, 3, 24'h002000, 0, 2'b11, 16'h1234, 3'b100, 16'h0000, 1, 2'b10, 8'h00, 0, 0);
		add_row(0, 3, 24'h002000, 0, 2'b11, 16'h1234, 3'b000, 16'h0000, 0, 2'b10, 8'h00, 0, 0);
		add_row(0, 3, 24'h01C060, 0, 2'b10, 16'h0000, 3'b000, 16'h0000, 1, 2'b00, 8'h00, 0, 0);
		// Shadow on
		add_row(0, 3, 24'h001000, 1, 2'b11, 16'h0000, 3'b101, 16'hA001, 1, 2'b01, 8'h00, 1, 0);
		add_row(0, 3, 24'h00C000, 1, 2'b11, 16'h0000, 3'b000, 16'hB002, 1, 2'b00, 8'h00, 1, 0);
		add_row(0, 3, 24'h00FEE4, 1, 2'b11, 16'h0000, 3'b010, 16'h7C7C, 1, 2'b00, 8'h00, 1, 0);
		add_row(0, 3, 24'h002000, 0, 2'b11, 16'h1234, 3'b000, 16'h0000, 1, 2'b00, 8'h00, 1, 0);
		add_row(0, 3, 24'h01C064, 0, 2'b10, 16'h0000, 3'b000, 16'h0000, 1, 2'b00, 8'h00, 1, 0);
		add_row(0, 3, 24'h001000, 1, 2'b11, 16'h0000, 3'b000, 16'hC003, 1, 2'b00, 8'h00, 0, 0);
	endtask

	task automatic apply_reset(input logic [1:0] cfg, input ql_bus_pkg::bus_speed_t spd);
		@(negedge clk_sys);
		reset   = 1'b1;
		ram_cfg = ql_bus_pkg::ram_cfg_t'(cfg);   // Latched while reset is high
		speed   = spd;
		bus.as  = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
	endtask

	task automatic run_row(input row_t r, input int idx);
		int waited;
		@(negedge clk_sys);
		bus.addr = r.addr;
		bus.as   = 1'b1;
		bus.rw   = r.rw;
		bus.uds  = r.ds[1];
		bus.lds  = r.ds[0];
		bus.dout = r.dout;
		{sdram_dtack, qlsd_dtack, ram_delay_dtack} = r.acks;
		exp_din    = r.din;
		chk_din    = r.rw;
		exp_dtack  = r.dtack;
		exp_strb   = r.strb;
		exp_waddr  = {1'b0, r.addr[23:1]};   // Byte address to 16-bit word address
		exp_mc     = r.mc;
		exp_shadow = r.shadow;
		exp_sel    = r.psel;
		row_seq    = idx;        // Checker compares on the next rising edge
		@(posedge clk_sys);
		waited = 1;
		while (r.dtack && !cpu_dtack && waited < DTACK_LIMIT)
		begin
			@(posedge clk_sys);
			waited++;
		end
		if (r.dtack && !cpu_dtack)
			u_checker.note_failure($sformatf("row %0d: bus cycle got no DTACK within %0d clocks",
				idx, DTACK_LIMIT));
	endtask

	// Ticks over the first 4096 clocks out of reset
	task automatic count_enables(input ql_bus_pkg::bus_speed_t spd, input int inc,
		input string label);
		int n_p;
		int n_n;
		int n_131;
		int ticks;
		n_p   = 0;
		n_n   = 0;
		n_131 = 0;
		apply_reset(2'd0, spd);
		repeat (ENABLE_CLOCKS)
		begin
			@(posedge clk_sys);
			@(negedge clk_sys);   // Registered pulses are stable here
			n_p   += ce_bus_p;
			n_n   += ce_bus_n;
			n_131 += ce_131k;
		end
		ticks = ENABLE_CLOCKS * inc / 65536;
		u_checker.check_enables(label, (ticks + 1) / 2, n_p, ticks / 2, n_n,
			(ENABLE_CLOCKS + 639) / 640, n_131);
	endtask

	// ==========================================================
	// Main sequence
	// ==========================================================
	initial
	begin
		reset           = 1'b1;
		speed           = ql_bus_pkg::SPEED_QL;
		ram_cfg         = ql_bus_pkg::RAM_128K;
		bus             = '0;
		sdram_dtack     = 1'b0;
		qlsd_dtack      = 1'b0;
		ram_delay_dtack = 1'b0;
		row_seq         = 0;
		exp_din         = 16'h0000;
		chk_din         = 1'b0;
		exp_dtack       = 1'b0;
		exp_strb        = 2'b00;
		exp_waddr       = 24'h000000;
		exp_mc          = 8'h00;
		exp_shadow      = 1'b0;
		exp_sel         = 3'b000;
		src.sdram_dout  = 16'hA001;
		src.ql_rom_dout = 16'hB002;
		src.gc_rom_dout = 16'hC003;
		src.zx8302_dout = 16'hD004;
		src.qimi_data   = 8'h5E;
		src.qlsd_dout   = 8'h7C;
		build_table();
		foreach (rows[i])
		begin
			if (rows[i].rst)
				apply_reset(rows[i].cfg, ql_bus_pkg::SPEED_QL);
			run_row(rows[i], i + 1);
		end
		count_enables(ql_bus_pkg::SPEED_QL, 11702, "enables QL");
		count_enables(ql_bus_pkg::SPEED_16, 24966, "enables 16 MHz");
		count_enables(ql_bus_pkg::SPEED_24, 37449, "enables 24 MHz");
		count_enables(ql_bus_pkg::SPEED_FULL, 65536, "enables full");
		u_checker.summary(ok);
		if (ok)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule
